// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

    ////////////////////
    // Widths

    localparam int WORD_WIDTH     = 16;
    localparam int REG_ADDR_WIDTH = 2;
    localparam int NUM_REGS       = 4;

    // Instruction fields
    localparam int OPCODE_MSB = 15;
    localparam int RS_MSB     = 11;
    localparam int RT_MSB     = 9;
    localparam int RD_MSB     = 7;   // R-type only
    localparam int FUNCT_MSB  = 5;
    localparam int IMM_WIDTH  = 8;   // I-type bits 7..0

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    ////////////////////
    // Encodings

    typedef enum logic [3:0] {
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADD = 6'd0,
        F_SUB = 6'd1,
        F_AND = 6'd2,
        F_ORR = 6'd3,
        F_NOT = 6'd4,
        F_TCP = 6'd5,
        F_SHL = 6'd6,
        F_SHR = 6'd7,
        F_WWD = 6'd28,
        F_HLT = 6'd29
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOT,
        ALU_TCP,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS_B
    } alu_op_e;

    ////////////////////
    // Pipeline payloads

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t dest;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        alu_op_e   alu_op;
        logic      use_imm;
        logic      reg_write;
        logic      wwd;
        logic      halt;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      wr_en;      // Already qualified by valid
        reg_addr_t dest;
        word_t     result;
        logic      wwd;
        word_t     wwd_data;
        logic      halt;
    } ex_wb_t;

endpackage

// ==== hw/register_file.sv ====
`timescale 1ns/1ns

module register_file (
    input  logic                clk,
    input  logic                reset_n,
    input  cpu_pkg::reg_addr_t  rs_addr,
    input  cpu_pkg::reg_addr_t  rt_addr,
    output cpu_pkg::word_t      rs_data,
    output cpu_pkg::word_t      rt_data,
    input  cpu_pkg::reg_write_t wr
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            regs <= '{default: '0};
        end else if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Write-through so a read during the write sees the new value
    assign rs_data = (wr.en && wr.addr == rs_addr) ? wr.data : regs[rs_addr];
    assign rt_data = (wr.en && wr.addr == rt_addr) ? wr.data : regs[rt_addr];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   y
);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: begin
                y = a + b;          // Wraps
            end
            cpu_pkg::ALU_SUB: begin
                y = a - b;
            end
            cpu_pkg::ALU_AND: begin
                y = a & b;
            end
            cpu_pkg::ALU_OR: begin
                y = a | b;
            end
            cpu_pkg::ALU_NOT: begin
                y = ~a;
            end
            cpu_pkg::ALU_TCP: begin
                y = ~a + 1'b1;      // Two's complement of rs
            end
            cpu_pkg::ALU_SHL: begin
                y = a << 1;
            end
            cpu_pkg::ALU_SHR: begin
                y = cpu_pkg::word_t'($signed(a) >>> 1);  // Sign bit kept
            end
            cpu_pkg::ALU_PASS_B: begin
                y = b;              // LHI
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
    input  logic                clk,
    input  logic                reset_n,
    input  cpu_pkg::word_t      inst,
    input  logic                inst_valid,
    output logic                inst_ready,
    input  cpu_pkg::reg_write_t wb_write,
    output cpu_pkg::id_ex_t     id_ex
);

    localparam int EXT_WIDTH = cpu_pkg::WORD_WIDTH - cpu_pkg::IMM_WIDTH;

    logic                          accept;
    logic                          fetch_hlt;
    logic                          halt_seen;
    logic                          if_valid;
    cpu_pkg::word_t                if_inst;
    cpu_pkg::opcode_e              opcode;
    cpu_pkg::funct_e               funct;
    cpu_pkg::reg_addr_t            rs;
    cpu_pkg::reg_addr_t            rt;
    cpu_pkg::reg_addr_t            rd;
    logic [cpu_pkg::IMM_WIDTH-1:0] imm8;
    cpu_pkg::word_t                rs_data;
    cpu_pkg::word_t                rt_data;
    cpu_pkg::id_ex_t               id_ex_d;

    ////////////////////
    // Fetch handshake

    assign inst_ready = ~halt_seen;
    assign accept     = inst_valid & inst_ready;
    assign fetch_hlt  = inst[cpu_pkg::OPCODE_MSB -: $bits(cpu_pkg::opcode_e)] == cpu_pkg::OP_RTYPE
                     && inst[cpu_pkg::FUNCT_MSB:0] == cpu_pkg::F_HLT;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_seen <= 1'b0;
            if_valid  <= 1'b0;
        end else begin
            if_valid <= accept;         // Bubble when nothing taken
            if (accept && fetch_hlt) begin
                halt_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if_inst <= inst;
        end
    end

    ////////////////////
    // Decode

    assign opcode = cpu_pkg::opcode_e'(if_inst[cpu_pkg::OPCODE_MSB -: $bits(cpu_pkg::opcode_e)]);
    assign funct  = cpu_pkg::funct_e'(if_inst[cpu_pkg::FUNCT_MSB:0]);
    assign rs     = if_inst[cpu_pkg::RS_MSB -: cpu_pkg::REG_ADDR_WIDTH];
    assign rt     = if_inst[cpu_pkg::RT_MSB -: cpu_pkg::REG_ADDR_WIDTH];
    assign rd     = if_inst[cpu_pkg::RD_MSB -: cpu_pkg::REG_ADDR_WIDTH];
    assign imm8   = if_inst[cpu_pkg::IMM_WIDTH-1:0];

    register_file i_register_file (
        .clk     (clk),
        .reset_n (reset_n),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wr      (wb_write)
    );

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.valid   = if_valid;
        id_ex_d.rs      = rs;
        id_ex_d.rt      = rt;
        id_ex_d.dest    = rt;           // Immediate group
        id_ex_d.rs_data = rs_data;
        id_ex_d.rt_data = rt_data;
        id_ex_d.alu_op  = cpu_pkg::ALU_ADD;
        case (opcode)
            cpu_pkg::OP_ADI: begin
                id_ex_d.imm       = {{EXT_WIDTH{imm8[cpu_pkg::IMM_WIDTH-1]}}, imm8};
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                id_ex_d.imm       = {{EXT_WIDTH{1'b0}}, imm8};
                id_ex_d.alu_op    = cpu_pkg::ALU_OR;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            cpu_pkg::OP_LHI: begin
                id_ex_d.imm       = {imm8, {EXT_WIDTH{1'b0}}};
                id_ex_d.alu_op    = cpu_pkg::ALU_PASS_B;
                id_ex_d.use_imm   = 1'b1;
                id_ex_d.reg_write = 1'b1;
            end
            cpu_pkg::OP_RTYPE: begin
                id_ex_d.dest      = rd;
                id_ex_d.reg_write = 1'b1;
                case (funct)
                    cpu_pkg::F_ADD: id_ex_d.alu_op = cpu_pkg::ALU_ADD;
                    cpu_pkg::F_SUB: id_ex_d.alu_op = cpu_pkg::ALU_SUB;
                    cpu_pkg::F_AND: id_ex_d.alu_op = cpu_pkg::ALU_AND;
                    cpu_pkg::F_ORR: id_ex_d.alu_op = cpu_pkg::ALU_OR;
                    cpu_pkg::F_NOT: id_ex_d.alu_op = cpu_pkg::ALU_NOT;
                    cpu_pkg::F_TCP: id_ex_d.alu_op = cpu_pkg::ALU_TCP;
                    cpu_pkg::F_SHL: id_ex_d.alu_op = cpu_pkg::ALU_SHL;
                    cpu_pkg::F_SHR: id_ex_d.alu_op = cpu_pkg::ALU_SHR;
                    cpu_pkg::F_WWD: begin
                        id_ex_d.wwd       = 1'b1;
                        id_ex_d.reg_write = 1'b0;
                    end
                    cpu_pkg::F_HLT: begin
                        id_ex_d.halt      = 1'b1;
                        id_ex_d.reg_write = 1'b0;
                    end
                    default: id_ex_d.reg_write = 1'b0;   // No-op that still retires
                endcase
            end
            default: ;                  // Undefined opcode decodes as no-op
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex.valid <= 1'b0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
    input  logic            clk,
    input  logic            reset_n,
    input  cpu_pkg::id_ex_t id_ex,
    output cpu_pkg::ex_wb_t ex_wb
);

    cpu_pkg::word_t  rs_fwd;
    cpu_pkg::word_t  rt_fwd;
    cpu_pkg::word_t  alu_b;
    cpu_pkg::word_t  alu_y;
    cpu_pkg::ex_wb_t ex_wb_d;

    ////////////////////
    // Forwarding from the stage ahead

    assign rs_fwd = (ex_wb.wr_en && ex_wb.dest == id_ex.rs) ? ex_wb.result : id_ex.rs_data;
    assign rt_fwd = (ex_wb.wr_en && ex_wb.dest == id_ex.rt) ? ex_wb.result : id_ex.rt_data;

    assign alu_b = id_ex.use_imm ? id_ex.imm : rt_fwd;

    alu i_alu (
        .op (id_ex.alu_op),
        .a  (rs_fwd),
        .b  (alu_b),
        .y  (alu_y)
    );

    always_comb begin
        ex_wb_d.valid    = id_ex.valid;
        ex_wb_d.wr_en    = id_ex.valid & id_ex.reg_write;
        ex_wb_d.dest     = id_ex.dest;
        ex_wb_d.result   = alu_y;
        ex_wb_d.wwd      = id_ex.wwd;
        ex_wb_d.wwd_data = rs_fwd;      // WWD prints rs
        ex_wb_d.halt     = id_ex.halt;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_wb.valid <= 1'b0;
            ex_wb.wr_en <= 1'b0;
        end else begin
            ex_wb <= ex_wb_d;
        end
    end

endmodule

// ==== hw/retire_unit.sv ====
`timescale 1ns/1ns

module retire_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  cpu_pkg::ex_wb_t     ex_wb,
    output cpu_pkg::reg_write_t wb_write,
    output cpu_pkg::word_t      output_port,
    output cpu_pkg::word_t      num_inst,
    output logic                is_halted
);

    // Register file takes this at the retire edge
    assign wb_write = '{en: ex_wb.wr_en, addr: ex_wb.dest, data: ex_wb.result};

    always_ff @(posedge clk) begin
        if (reset_n) begin
            output_port <= '0;
            num_inst    <= '0;
            is_halted   <= 1'b0;
        end else if (ex_wb.valid) begin
            num_inst <= num_inst + 1'b1;    // Every retirement including no-ops
            if (ex_wb.wwd) begin
                output_port <= ex_wb.wwd_data;
            end
            if (ex_wb.halt) begin
                is_halted <= 1'b1;          // Sticky until reset
            end
        end
    end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ns

module cpu (
    input  logic           clk,
    input  logic           reset_n,
    input  cpu_pkg::word_t inst,
    input  logic           inst_valid,
    output logic           inst_ready,
    output cpu_pkg::word_t output_port,
    output cpu_pkg::word_t num_inst,
    output logic           is_halted
);

    cpu_pkg::id_ex_t     id_ex;
    cpu_pkg::ex_wb_t     ex_wb;
    cpu_pkg::reg_write_t wb_write;     // Retire back to the register file

    decode_stage i_decode_stage (
        .clk        (clk),
        .reset_n    (reset_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .wb_write   (wb_write),
        .id_ex      (id_ex)
    );

    execute_stage i_execute_stage (
        .clk     (clk),
        .reset_n (reset_n),
        .id_ex   (id_ex),
        .ex_wb   (ex_wb)
    );

    retire_unit i_retire_unit (
        .clk         (clk),
        .reset_n     (reset_n),
        .ex_wb       (ex_wb),
        .wb_write    (wb_write),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

endmodule

// ==== sim/cpu_chk.sv ====
`timescale 1ns/1ns

module cpu_chk (
    input logic           clk,
    input logic           reset_n,
    input logic           inst_ready,
    input cpu_pkg::word_t num_inst,
    input logic           is_halted
);

    ////////////////////
    // Halt

    halted_sticky: assert property (
        @(posedge clk) disable iff (reset_n) is_halted |=> is_halted
    ) else $error("is_halted fell while out of reset");

    fetch_closed: assert property (
        @(posedge clk) disable iff (reset_n) is_halted |-> !inst_ready
    ) else $error("inst_ready high while halted");

    // At most one retirement per cycle
    count_step: assert property (
        @(posedge clk) disable iff (reset_n)
        1'b1 |=> (num_inst == $past(num_inst)
                  || num_inst == cpu_pkg::word_t'($past(num_inst) + 16'd1))
    ) else $error("num_inst moved by more than one");

endmodule

bind cpu cpu_chk i_cpu_chk (
    .clk        (clk),
    .reset_n    (reset_n),
    .inst_ready (inst_ready),
    .num_inst   (num_inst),
    .is_halted  (is_halted)
);

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu;

    localparam int unsigned SEED       = 32'h58cd_7302;
    localparam int          NUM_STIM   = 300;     // Instructions before HLT
    localparam int          STIM_LIMIT = 2000;    // Cycles
    localparam int          HALT_LIMIT = 20;

    // One accepted instruction on its way to retirement
    typedef struct packed {
        int             due;
        logic           wwd;
        logic           halt;
        cpu_pkg::word_t value;
    } retire_t;

    logic           clk;
    logic           reset_n;
    cpu_pkg::word_t inst;
    logic           inst_valid;
    logic           inst_ready;
    cpu_pkg::word_t output_port;
    cpu_pkg::word_t num_inst;
    logic           is_halted;

    cpu_pkg::word_t     regs [cpu_pkg::NUM_REGS];
    retire_t            pending [$];
    cpu_pkg::reg_addr_t last_dest;
    cpu_pkg::reg_addr_t prev_dest;
    cpu_pkg::word_t     exp_port;
    cpu_pkg::word_t     exp_num;
    logic               exp_halted;
    logic               hlt_driven;
    logic               hlt_accepted;
    logic               seen_halted;
    int                 edge_cnt;
    int                 issued;
    int                 accepted;
    int                 checks;
    int                 errors;

    always #5 clk = ~clk;

    cpu i_cpu (
        .clk         (clk),
        .reset_n     (reset_n),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .inst_ready  (inst_ready),
        .output_port (output_port),
        .num_inst    (num_inst),
        .is_halted   (is_halted)
    );

    task automatic compare(input string name, input cpu_pkg::word_t actual,
                           input cpu_pkg::word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    ////////////////////
    // Stimulus

    function automatic cpu_pkg::word_t encode_r(cpu_pkg::funct_e f, cpu_pkg::reg_addr_t rs,
                                                cpu_pkg::reg_addr_t rt, cpu_pkg::reg_addr_t rd);
        return {cpu_pkg::OP_RTYPE, rs, rt, rd, f};
    endfunction

    function automatic cpu_pkg::word_t encode_i(cpu_pkg::opcode_e op, cpu_pkg::reg_addr_t rs,
                                                cpu_pkg::reg_addr_t rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Mostly the newest or second newest destination
    function automatic cpu_pkg::reg_addr_t pick_reg();
        int unsigned sel;
        sel = $urandom % 3;
        if (sel == 0) begin
            return last_dest;
        end else if (sel == 1) begin
            return prev_dest;
        end
        return cpu_pkg::reg_addr_t'($urandom % cpu_pkg::NUM_REGS);
    endfunction

    function automatic cpu_pkg::word_t random_inst();
        int unsigned        kind;
        logic [7:0]         imm;
        cpu_pkg::reg_addr_t rd;
        kind = $urandom % 16;
        imm  = 8'($urandom);
        rd   = cpu_pkg::reg_addr_t'($urandom % cpu_pkg::NUM_REGS);
        if (kind < 6) begin
            return encode_r(cpu_pkg::F_WWD, pick_reg(), pick_reg(), rd);
        end else if (kind < 11) begin
            return encode_r(cpu_pkg::funct_e'(6'($urandom % 8)), pick_reg(), pick_reg(), rd);
        end else if (kind < 13) begin
            return encode_i(cpu_pkg::OP_ADI, pick_reg(), rd, imm);
        end else if (kind < 15) begin
            return encode_i(cpu_pkg::OP_ORI, pick_reg(), rd, imm);
        end
        return encode_i(cpu_pkg::OP_LHI, pick_reg(), rd, imm);
    endfunction

    task automatic drive_inputs();
        if (hlt_driven) begin
            inst_valid <= 1'b1;                 // Must be refused
            inst       <= random_inst();
        end else if ($urandom % 4 == 0) begin
            inst_valid <= 1'b0;
            inst       <= random_inst();
        end else if (issued == NUM_STIM) begin
            inst_valid <= 1'b1;
            inst       <= encode_r(cpu_pkg::F_HLT, 2'd0, 2'd0, 2'd0);
            hlt_driven = 1'b1;
        end else begin
            inst_valid <= 1'b1;
            inst       <= random_inst();
            issued++;
        end
    endtask

    ////////////////////
    // Reference model

    task automatic write_reg(input cpu_pkg::reg_addr_t dest, input cpu_pkg::word_t value);
        regs[dest] = value;
        prev_dest  = last_dest;
        last_dest  = dest;
    endtask

    task automatic accept_inst(input cpu_pkg::word_t w, input int edge_no);
        cpu_pkg::opcode_e              op;
        cpu_pkg::funct_e               fn;
        cpu_pkg::reg_addr_t            rs;
        cpu_pkg::reg_addr_t            rt;
        cpu_pkg::reg_addr_t            rd;
        logic [cpu_pkg::IMM_WIDTH-1:0] imm8;
        cpu_pkg::word_t                a;
        cpu_pkg::word_t                b;
        retire_t                       r;
        op   = cpu_pkg::opcode_e'(w[cpu_pkg::OPCODE_MSB -: 4]);
        fn   = cpu_pkg::funct_e'(w[cpu_pkg::FUNCT_MSB:0]);
        rs   = w[cpu_pkg::RS_MSB -: 2];
        rt   = w[cpu_pkg::RT_MSB -: 2];
        rd   = w[cpu_pkg::RD_MSB -: 2];
        imm8 = w[cpu_pkg::IMM_WIDTH-1:0];
        a    = regs[rs];
        b    = regs[rt];
        r    = '{due: edge_no + 3, wwd: 1'b0, halt: 1'b0, value: a};
        accepted++;
        case (op)
            cpu_pkg::OP_ADI: write_reg(rt, a + {{8{imm8[7]}}, imm8});
            cpu_pkg::OP_ORI: write_reg(rt, a | {8'h00, imm8});
            cpu_pkg::OP_LHI: write_reg(rt, {imm8, 8'h00});
            cpu_pkg::OP_RTYPE: begin
                case (fn)
                    cpu_pkg::F_ADD: write_reg(rd, a + b);
                    cpu_pkg::F_SUB: write_reg(rd, a - b);
                    cpu_pkg::F_AND: write_reg(rd, a & b);
                    cpu_pkg::F_ORR: write_reg(rd, a | b);
                    cpu_pkg::F_NOT: write_reg(rd, ~a);
                    cpu_pkg::F_TCP: write_reg(rd, 16'd0 - a);
                    cpu_pkg::F_SHL: write_reg(rd, {a[14:0], 1'b0});
                    cpu_pkg::F_SHR: write_reg(rd, {a[15], a[15:1]});
                    cpu_pkg::F_WWD: r.wwd = 1'b1;
                    cpu_pkg::F_HLT: begin
                        r.halt       = 1'b1;
                        hlt_accepted = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        pending.push_back(r);
    endtask

    task automatic check_outputs();
        retire_t r;
        while (pending.size() > 0 && pending[0].due <= edge_cnt) begin
            r = pending.pop_front();
            exp_num++;
            if (r.wwd) begin
                exp_port = r.value;
            end
            if (r.halt) begin
                exp_halted = 1'b1;
            end
        end
        compare("output_port", output_port, exp_port);
        compare("num_inst", num_inst, exp_num);
        compare("is_halted", cpu_pkg::word_t'(is_halted), cpu_pkg::word_t'(exp_halted));
        compare("inst_ready", cpu_pkg::word_t'(inst_ready), cpu_pkg::word_t'(!hlt_accepted));
    endtask

    // Check and model at the falling edge, drive at the rising edge
    task automatic run_cycle();
        @(negedge clk);
        check_outputs();
        seen_halted = is_halted;
        if (inst_valid && !hlt_accepted) begin
            accept_inst(inst, edge_cnt + 1);
        end
        @(posedge clk);
        edge_cnt++;
        drive_inputs();
    endtask

    initial begin
        int wait_cycles;
        void'($urandom(SEED));
        clk          = 1'b0;
        reset_n      = 1'b1;
        inst         = '0;
        inst_valid   = 1'b0;
        regs         = '{default: '0};
        last_dest    = '0;
        prev_dest    = '0;
        exp_port     = '0;
        exp_num      = '0;
        exp_halted   = 1'b0;
        hlt_driven   = 1'b0;
        hlt_accepted = 1'b0;
        seen_halted  = 1'b0;
        edge_cnt     = 0;
        issued       = 0;
        accepted     = 0;
        checks       = 0;
        errors       = 0;

        repeat (5) @(posedge clk);
        reset_n <= 1'b0;
        drive_inputs();

        wait_cycles = 0;
        while (!hlt_accepted && wait_cycles < STIM_LIMIT) begin
            run_cycle();
            wait_cycles++;
        end
        if (!hlt_accepted) begin
            errors++;
            $display("Timeout: HLT was not accepted within %0d cycles", STIM_LIMIT);
        end

        wait_cycles = 0;
        while (!seen_halted && wait_cycles < HALT_LIMIT) begin
            run_cycle();
            wait_cycles++;
        end
        if (!seen_halted) begin
            errors++;
            $display("Timeout: is_halted did not rise within %0d cycles", HALT_LIMIT);
        end

        repeat (4) run_cycle();             // Fetch stays closed
        @(negedge clk);
        compare("num_inst", num_inst, cpu_pkg::word_t'(accepted));

        $display("Checks: %0d, errors: %0d, instructions accepted: %0d",
                 checks, errors, accepted);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hw/cpu_pkg.sv
hw/register_file.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/retire_unit.sv
hw/cpu.sv
sim/cpu_chk.sv
sim/tb_cpu.sv

// ==== Makefile ====
TOP := tb_cpu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f \
		-Mdir obj_dir -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
